//--- rtl/rv_exec_pkg.sv
`default_nettype none

package rv_exec_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    typedef enum logic [2:0] {
        class_alu    = 3'd0,
        class_branch = 3'd1,
        class_jump   = 3'd2,
        class_load   = 3'd3,
        class_store  = 3'd4,
        class_none   = 3'd5
    } op_class_e;

    // code space is reused per class, so plain constants instead of enum members
    typedef logic [3:0] inst_code_e;

    localparam inst_code_e inst_add  = 4'd0;
    localparam inst_code_e inst_sub  = 4'd1;
    localparam inst_code_e inst_and  = 4'd2;
    localparam inst_code_e inst_or   = 4'd3;
    localparam inst_code_e inst_xor  = 4'd4;
    localparam inst_code_e inst_sll  = 4'd5;
    localparam inst_code_e inst_srl  = 4'd6;
    localparam inst_code_e inst_sra  = 4'd7;
    localparam inst_code_e inst_slt  = 4'd8;
    localparam inst_code_e inst_sltu = 4'd9;

    localparam inst_code_e inst_beq  = 4'd0; // branch codes follow funct3
    localparam inst_code_e inst_bne  = 4'd1;
    localparam inst_code_e inst_blt  = 4'd4;
    localparam inst_code_e inst_bge  = 4'd5;
    localparam inst_code_e inst_bltu = 4'd6;
    localparam inst_code_e inst_bgeu = 4'd7;

    localparam inst_code_e inst_jal  = 4'd0;
    localparam inst_code_e inst_jalr = 4'd1;

    localparam inst_code_e inst_lb   = 4'd0;
    localparam inst_code_e inst_lh   = 4'd1;
    localparam inst_code_e inst_lw   = 4'd2;
    localparam inst_code_e inst_lbu  = 4'd4;
    localparam inst_code_e inst_lhu  = 4'd5;

    localparam inst_code_e inst_sb   = 4'd0;
    localparam inst_code_e inst_sh   = 4'd1;
    localparam inst_code_e inst_sw   = 4'd2;

    typedef enum logic [3:0] {
        op_add  = 4'd0,
        op_sub  = 4'd1,
        op_and  = 4'd2,
        op_or   = 4'd3,
        op_xor  = 4'd4,
        op_sll  = 4'd5,
        op_srl  = 4'd6,
        op_sra  = 4'd7,
        op_slt  = 4'd8,
        op_sltu = 4'd9
    } alu_op_e;

    typedef enum logic [1:0] {
        src_a_zero = 2'd0,
        src_a_reg  = 2'd1,
        src_a_pc   = 2'd2
    } src_a_e;

    typedef enum logic {
        src_b_imm = 1'b0,
        src_b_reg = 1'b1
    } src_b_e;

    typedef enum logic [1:0] {
        fwd_none   = 2'd0,
        fwd_ex_mem = 2'd1,
        fwd_mem_wb = 2'd2
    } fwd_sel_e;

    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } acc_size_e;

    typedef struct packed {
        logic                  valid;
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       pc_plus4;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [xlen-1:0]       rs1_data;
        logic [xlen-1:0]       rs2_data;
        logic [xlen-1:0]       imm;
        logic [reg_addr_w-1:0] rd;
        op_class_e             op_class;
        inst_code_e            inst_code;
        src_a_e                src_a;
        src_b_e                src_b;
        logic                  reg_write;
        logic                  mem_read;
        logic                  mem_write;
        logic                  is_jalr;
    } id_ex_t;

    typedef struct packed {
        logic                  valid;
        logic [xlen-1:0]       alu_result;
        logic [xlen-1:0]       store_data;
        logic [xlen-1:0]       branch_target;
        logic [xlen-1:0]       pc_plus4;
        logic                  branch_taken;
        logic [reg_addr_w-1:0] rd;
        logic                  reg_write;
        logic                  mem_read;
        logic                  mem_write;
        acc_size_e             size;
        logic                  load_unsigned;
    } ex_mem_t;

    typedef struct packed {
        logic                  write;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       data;
    } wb_fwd_t;

endpackage

`default_nettype wire

//--- rtl/forward_detect.sv
`timescale 1ns/1ps
`default_nettype none

module forward_detect import rv_exec_pkg::*; (
    input  wire logic [reg_addr_w-1:0] rs1,
    input  wire logic [reg_addr_w-1:0] rs2,
    input  wire ex_mem_t               ex_mem,
    input  wire wb_fwd_t               mem_wb,
    output fwd_sel_e                   fwd_a,
    output fwd_sel_e                   fwd_b
);

    function automatic fwd_sel_e pick_src(input logic [reg_addr_w-1:0] rs,
                                          input ex_mem_t em,
                                          input wb_fwd_t wb);
        fwd_sel_e sel;
        sel = fwd_none;
        // loads have no data yet in EX/MEM and come back through MEM/WB
        if (em.valid && em.reg_write && !em.mem_read && em.rd != '0 && em.rd == rs)
            sel = fwd_ex_mem;
        else if (wb.write && wb.rd != '0 && wb.rd == rs)
            sel = fwd_mem_wb;
        return sel;
    endfunction

    always_comb begin
        fwd_a = pick_src(rs1, ex_mem, mem_wb);
        fwd_b = pick_src(rs2, ex_mem, mem_wb);
    end

endmodule

`default_nettype wire

//--- rtl/operand_select.sv
`timescale 1ns/1ps
`default_nettype none

module operand_select import rv_exec_pkg::*; (
    input  wire id_ex_t          id_ex,
    input  wire fwd_sel_e        fwd_a,
    input  wire fwd_sel_e        fwd_b,
    input  wire logic [xlen-1:0] ex_result,
    input  wire logic [xlen-1:0] wb_data,
    output logic [xlen-1:0]      rs1_eff,
    output logic [xlen-1:0]      rs2_eff,
    output logic [xlen-1:0]      alu_a,
    output logic [xlen-1:0]      alu_b
);

    // forwarded register values, shared by ALU inputs, jalr target and store data
    always_comb begin
        case (fwd_a)
            fwd_ex_mem: rs1_eff = ex_result;
            fwd_mem_wb: rs1_eff = wb_data;
            default:    rs1_eff = id_ex.rs1_data;
        endcase

        case (fwd_b)
            fwd_ex_mem: rs2_eff = ex_result;
            fwd_mem_wb: rs2_eff = wb_data;
            default:    rs2_eff = id_ex.rs2_data;
        endcase
    end

    always_comb begin
        case (id_ex.src_a)
            src_a_reg: alu_a = rs1_eff;
            src_a_pc:  alu_a = id_ex.pc;   // auipc, jal link path
            default:   alu_a = '0;         // lui style: 0 + imm
        endcase

        if (id_ex.src_b == src_b_reg)
            alu_b = rs2_eff;
        else
            alu_b = id_ex.imm;
    end

endmodule

`default_nettype wire

//--- rtl/alu_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module alu_decoder import rv_exec_pkg::*; (
    input  wire op_class_e  op_class,
    input  wire inst_code_e inst_code,
    output alu_op_e         alu_op,
    output acc_size_e       size,
    output logic            load_unsigned,
    output logic            branch_invert
);

    logic code_ok;

    always_comb begin
        alu_op        = op_add;
        size          = size_word;
        load_unsigned = 1'b0;
        branch_invert = 1'b0;
        code_ok       = 1'b1;

        case (op_class)
            class_alu: begin
                if (inst_code <= inst_sltu)
                    alu_op = alu_op_e'(inst_code); // codes line up with alu_op_e
                else
                    code_ok = 1'b0;
            end
            class_branch: begin
                case (inst_code)
                    inst_beq:  alu_op = op_sub;
                    inst_bne:  begin alu_op = op_sub;  branch_invert = 1'b1; end
                    inst_blt:  alu_op = op_slt;
                    inst_bge:  begin alu_op = op_slt;  branch_invert = 1'b1; end
                    inst_bltu: alu_op = op_sltu;
                    inst_bgeu: begin alu_op = op_sltu; branch_invert = 1'b1; end
                    default:   code_ok = 1'b0;
                endcase
            end
            class_jump:
                code_ok = (inst_code == inst_jal) || (inst_code == inst_jalr);
            class_load: begin
                case (inst_code)
                    inst_lb:  size = size_byte;
                    inst_lh:  size = size_half;
                    inst_lw:  size = size_word;
                    inst_lbu: begin size = size_byte; load_unsigned = 1'b1; end
                    inst_lhu: begin size = size_half; load_unsigned = 1'b1; end
                    default:  code_ok = 1'b0;
                endcase
            end
            class_store: begin
                case (inst_code)
                    inst_sb: size = size_byte;
                    inst_sh: size = size_half;
                    inst_sw: size = size_word;
                    default: code_ok = 1'b0;
                endcase
            end
            class_none: ;                     // bubble, add 0 + 0
            default:    code_ok = 1'b0;
        endcase
    end

    always_comb begin
        if (!$isunknown({op_class, inst_code}))
            assert (code_ok) else $error("undefined inst_code %0d for class %0d",
                                         inst_code, op_class);
    end

endmodule

`default_nettype wire

//--- rtl/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import rv_exec_pkg::*; (
    input  wire alu_op_e         op,
    input  wire logic [xlen-1:0] a,
    input  wire logic [xlen-1:0] b,
    output logic [xlen-1:0]      result
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            op_add:  result = a + b;
            op_sub:  result = a - b;
            op_and:  result = a & b;
            op_or:   result = a | b;
            op_xor:  result = a ^ b;
            op_sll:  result = a << shamt;
            op_srl:  result = a >> shamt;
            op_sra:  result = $unsigned($signed(a) >>> shamt);
            op_slt:  result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            op_sltu: result = {{(xlen-1){1'b0}}, a < b};
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage import rv_exec_pkg::*; (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            keep,
    input  wire logic            nop,
    input  wire id_ex_t          id_ex,
    input  wire fwd_sel_e        fwd_a,
    input  wire fwd_sel_e        fwd_b,
    input  wire logic [xlen-1:0] wb_data,
    output ex_mem_t              ex_mem
);

    logic [xlen-1:0] rs1_eff;
    logic [xlen-1:0] rs2_eff;
    logic [xlen-1:0] alu_a;
    logic [xlen-1:0] alu_b;
    logic [xlen-1:0] alu_result;
    alu_op_e         alu_op;
    acc_size_e       size;
    logic            load_unsigned;
    logic            branch_invert;
    logic            cond;
    logic            taken;
    logic [xlen-1:0] target;
    logic [xlen-1:0] store_data;
    ex_mem_t         ex_next;

    operand_select operand_select_inst (
        .id_ex     (id_ex),
        .fwd_a     (fwd_a),
        .fwd_b     (fwd_b),
        .ex_result (ex_mem.alu_result),   // own EX/MEM result fed back
        .wb_data   (wb_data),
        .rs1_eff   (rs1_eff),
        .rs2_eff   (rs2_eff),
        .alu_a     (alu_a),
        .alu_b     (alu_b)
    );

    alu_decoder alu_decoder_inst (
        .op_class      (id_ex.op_class),
        .inst_code     (id_ex.inst_code),
        .alu_op        (alu_op),
        .size          (size),
        .load_unsigned (load_unsigned),
        .branch_invert (branch_invert)
    );

    alu alu_inst (
        .op     (alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result)
    );

    // beq/bne compare by subtraction and the rest by slt/sltu bit 0
    assign cond = (alu_op == op_sub) ? (alu_result == '0) : alu_result[0];

    always_comb begin
        case (id_ex.op_class)
            class_branch: taken = cond ^ branch_invert;
            class_jump:   taken = 1'b1;
            default:      taken = 1'b0;
        endcase
    end

    always_comb begin
        if (id_ex.is_jalr)
            target = (rs1_eff + id_ex.imm) & ~32'd1;
        else
            target = id_ex.pc + id_ex.imm;
    end

    always_comb begin
        case (size)
            size_byte: store_data = {24'b0, rs2_eff[7:0]};
            size_half: store_data = {16'b0, rs2_eff[15:0]};
            default:   store_data = rs2_eff;
        endcase
    end

    always_comb begin
        ex_next.valid         = 1'b1;
        ex_next.alu_result    = alu_result;
        ex_next.store_data    = store_data;
        ex_next.branch_target = target;
        ex_next.pc_plus4      = id_ex.pc_plus4;
        ex_next.branch_taken  = taken;
        ex_next.rd            = id_ex.rd;
        ex_next.reg_write     = id_ex.reg_write;
        ex_next.mem_read      = id_ex.mem_read;
        ex_next.mem_write     = id_ex.mem_write;
        ex_next.size          = size;
        ex_next.load_unsigned = load_unsigned;
    end

    // reset, then keep, then nop, then load
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ex_mem <= '0;
        end else if (!keep) begin
            if (nop || !id_ex.valid)
                ex_mem <= '0;                // bubble
            else
                ex_mem <= ex_next;
        end
    end

    a_no_rw_both: assert property (@(posedge clk) disable iff (!rst)
        !(ex_mem.mem_read && ex_mem.mem_write))
        else $error("mem_read and mem_write both set in EX/MEM");

endmodule

`default_nettype wire

//--- rtl/exec_top.sv
`timescale 1ns/1ps
`default_nettype none

module exec_top import rv_exec_pkg::*; (
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire logic    keep,
    input  wire logic    nop,
    input  wire id_ex_t  id_ex,
    input  wire wb_fwd_t mem_wb,
    output ex_mem_t      ex_mem
);

    fwd_sel_e fwd_a;
    fwd_sel_e fwd_b;

    forward_detect forward_detect_inst (
        .rs1    (id_ex.rs1),
        .rs2    (id_ex.rs2),
        .ex_mem (ex_mem),      // registered output loops back for forwarding
        .mem_wb (mem_wb),
        .fwd_a  (fwd_a),
        .fwd_b  (fwd_b)
    );

    execute_stage execute_stage_inst (
        .clk     (clk),
        .rst     (rst),
        .keep    (keep),
        .nop     (nop),
        .id_ex   (id_ex),
        .fwd_a   (fwd_a),
        .fwd_b   (fwd_b),
        .wb_data (mem_wb.data),
        .ex_mem  (ex_mem)
    );

endmodule

`default_nettype wire

//--- verification/tb_exec_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_exec_top import rv_exec_pkg::*;;

    localparam int reset_cycles = 2;
    localparam int n_idle       = 4;
    localparam int n_alu        = 120;
    localparam int n_fwd        = 120;
    localparam int n_branch     = 80;
    localparam int n_mem        = 80;
    localparam int n_keep_nop   = 100;
    localparam int total_cycles = reset_cycles + n_idle + n_alu + n_fwd + n_branch
                                  + n_mem + n_keep_nop + 1;

    logic    clk;
    logic    rst;
    logic    keep;
    logic    nop;
    id_ex_t  id_ex;
    wb_fwd_t mem_wb;
    ex_mem_t ex_mem;

    ex_mem_t exp_mem;          // model copy of EX/MEM
    string   exp_name;
    string   applied_name;
    int      errors = 0;
    int      checks = 0;
    integer  seed = 32'hddd1_f558;

    exec_top exec_top_inst (
        .clk    (clk),
        .rst    (rst),
        .keep   (keep),
        .nop    (nop),
        .id_ex  (id_ex),
        .mem_wb (mem_wb),
        .ex_mem (ex_mem)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic int unsigned rnd(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // only codes that are defined for the class
    function automatic inst_code_e pick_code(input op_class_e cls);
        int unsigned k;
        case (cls)
            class_alu:    return 4'(rnd(10));
            class_branch: begin
                k = rnd(6);
                return (k < 2) ? 4'(k) : 4'(k + 2);      // 0 1 4 5 6 7
            end
            class_jump:   return 4'(rnd(2));
            class_load:   begin
                k = rnd(5);
                return (k < 3) ? 4'(k) : 4'(k + 1);      // 0 1 2 4 5
            end
            class_store:  return 4'(rnd(3));
            default:      return 4'd0;
        endcase
    endfunction

    function automatic id_ex_t make_instr(input op_class_e cls);
        id_ex_t d;
        d           = '0;
        d.valid     = 1'b1;
        d.pc        = $random(seed) & 32'hffff_fffc;
        d.pc_plus4  = d.pc + 32'd4;
        d.rs1       = 5'(rnd(4));   // x0..x3 keeps dependences frequent
        d.rs2       = 5'(rnd(4));
        d.rd        = 5'(rnd(4));
        d.rs1_data  = $random(seed);
        d.rs2_data  = $random(seed);
        d.imm       = $random(seed);
        d.op_class  = cls;
        d.inst_code = pick_code(cls);
        d.src_a     = src_a_reg;
        d.src_b     = src_b_imm;
        case (cls)
            class_alu: begin
                d.src_b = (rnd(2) == 0) ? src_b_reg : src_b_imm;
                case (rnd(8))
                    0:       d.src_a = src_a_pc;
                    1:       d.src_a = src_a_zero;
                    default: d.src_a = src_a_reg;
                endcase
                d.reg_write = 1'b1;
            end
            class_branch: begin
                d.src_b = src_b_reg;
                if (rnd(2) == 0) begin
                    // same register so equal compares happen
                    d.rs2      = d.rs1;
                    d.rs2_data = d.rs1_data;
                end
            end
            class_jump: begin
                d.src_a     = src_a_pc;
                d.is_jalr   = (d.inst_code == inst_jalr);
                d.reg_write = 1'b1;
            end
            class_load: begin
                d.mem_read  = 1'b1;
                d.reg_write = 1'b1;
            end
            class_store: d.mem_write = 1'b1;
            default: ;
        endcase
        return d;
    endfunction

    function automatic id_ex_t idle_instr();
        id_ex_t d;
        d       = make_instr(class_alu);
        d.valid = 1'b0;               // junk fields without the strobe
        return d;
    endfunction

    function automatic logic [xlen-1:0] fwd_value(input logic [reg_addr_w-1:0] rs,
                                                  input logic [xlen-1:0] rf,
                                                  input ex_mem_t em,
                                                  input wb_fwd_t wb);
        if (em.valid && em.reg_write && !em.mem_read && em.rd != 0 && em.rd == rs)
            return em.alu_result;
        if (wb.write && wb.rd != 0 && wb.rd == rs)
            return wb.data;
        return rf;
    endfunction

    function automatic logic [xlen-1:0] alu_ref(input inst_code_e code,
                                                input logic [xlen-1:0] a,
                                                input logic [xlen-1:0] b);
        case (code)
            inst_add:  return a + b;
            inst_sub:  return a - b;
            inst_and:  return a & b;
            inst_or:   return a | b;
            inst_xor:  return a ^ b;
            inst_sll:  return a << b[4:0];
            inst_srl:  return a >> b[4:0];
            inst_sra:  return $signed(a) >>> b[4:0];
            inst_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:   return (a < b) ? 32'd1 : 32'd0;
        endcase
    endfunction

    function automatic logic branch_ref(input inst_code_e code,
                                        input logic [xlen-1:0] a,
                                        input logic [xlen-1:0] b);
        case (code)
            inst_beq:  return a == b;
            inst_bne:  return a != b;
            inst_blt:  return $signed(a) < $signed(b);
            inst_bge:  return $signed(a) >= $signed(b);
            inst_bltu: return a < b;
            default:   return a >= b;
        endcase
    endfunction

    function automatic ex_mem_t ref_ex_mem(input id_ex_t d, input logic k, input logic n,
                                           input wb_fwd_t wb, input ex_mem_t prev);
        ex_mem_t         r;
        logic [xlen-1:0] v1;
        logic [xlen-1:0] v2;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] res;
        logic            tk;
        acc_size_e       sz;
        r = '0;
        if (k)
            return prev;              // hold
        if (n || !d.valid)
            return r;                 // bubble
        v1 = fwd_value(d.rs1, d.rs1_data, prev, wb);
        v2 = fwd_value(d.rs2, d.rs2_data, prev, wb);
        case (d.src_a)
            src_a_reg: a = v1;
            src_a_pc:  a = d.pc;
            default:   a = '0;
        endcase
        b   = (d.src_b == src_b_reg) ? v2 : d.imm;
        res = a + b;                  // jumps, loads, stores
        tk  = 1'b0;
        sz  = size_word;
        case (d.op_class)
            class_alu:    res = alu_ref(d.inst_code, a, b);
            class_branch: begin
                case (d.inst_code)
                    inst_beq, inst_bne: res = a - b;
                    inst_blt, inst_bge: res = alu_ref(inst_slt, a, b);
                    default:            res = alu_ref(inst_sltu, a, b);
                endcase
                tk = branch_ref(d.inst_code, a, b);
            end
            class_jump:   tk = 1'b1;
            class_load, class_store: begin
                case (d.inst_code)
                    inst_lb, inst_lbu: sz = size_byte;   // sb shares code 0
                    inst_lh, inst_lhu: sz = size_half;
                    default:           sz = size_word;
                endcase
            end
            default: ;
        endcase
        r.valid         = 1'b1;
        r.alu_result    = res;
        case (sz)
            size_byte: r.store_data = {24'b0, v2[7:0]};
            size_half: r.store_data = {16'b0, v2[15:0]};
            default:   r.store_data = v2;
        endcase
        r.branch_target = d.is_jalr ? ((v1 + d.imm) & 32'hffff_fffe) : (d.pc + d.imm);
        r.pc_plus4      = d.pc_plus4;
        r.branch_taken  = tk;
        r.rd            = d.rd;
        r.reg_write     = d.reg_write;
        r.mem_read      = d.mem_read;
        r.mem_write     = d.mem_write;
        r.size          = sz;
        r.load_unsigned = (d.op_class == class_load)
                          && (d.inst_code == inst_lbu || d.inst_code == inst_lhu);
        return r;
    endfunction

    // update the model from the sampled inputs and drive the next cycle
    task automatic step(input string name, input id_ex_t d, input logic k, input logic n);
        wb_fwd_t wb;
        @(posedge clk);
        if (!rst)
            exp_mem = '0;
        else
            exp_mem = ref_ex_mem(id_ex, keep, nop, mem_wb, exp_mem);
        exp_name = applied_name;
        wb.write = (rnd(2) == 0);
        wb.rd    = 5'(rnd(4));
        wb.data  = $random(seed);
        id_ex  <= d;
        keep   <= k;
        nop    <= n;
        mem_wb <= wb;
        applied_name = name;
    endtask

    // compare half a cycle after each edge
    initial begin
        @(posedge clk);
        forever begin
            @(negedge clk);
            checks++;
            if (ex_mem !== exp_mem) begin
                errors++;
                $display("** Error %s: expected %h, actual %h", exp_name, exp_mem, ex_mem);
            end
        end
    end

    initial begin
        #((total_cycles + 50) * 20);
        $display("timeout: the run did not finish within %0d cycles", total_cycles + 50);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        rst          = 1'b0;
        keep         = 1'b0;
        nop          = 1'b0;
        id_ex        = '0;
        mem_wb       = '0;
        exp_mem      = '0;
        applied_name = "reset";
        exp_name     = "reset";

        repeat (reset_cycles) step("reset", idle_instr(), 1'b0, 1'b0);
        rst <= 1'b1;
        repeat (n_idle) step("idle", idle_instr(), 1'b0, 1'b0);
        repeat (n_alu) step("alu", make_instr(class_alu), 1'b0, 1'b0);
        repeat (n_fwd)
            step("forward", make_instr(rnd(4) == 0 ? class_load : class_alu), 1'b0, 1'b0);
        repeat (n_branch)
            step("branch", make_instr(rnd(3) == 0 ? class_jump : class_branch), 1'b0, 1'b0);
        repeat (n_mem)
            step("load_store", make_instr(rnd(2) == 0 ? class_load : class_store), 1'b0, 1'b0);
        repeat (n_keep_nop)
            step("keep_nop", make_instr(op_class_e'(rnd(5))), rnd(4) == 0, rnd(4) == 0);
        step("drain", idle_instr(), 1'b0, 1'b0);
        @(negedge clk);
        #1;

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- rv_exec.f
rtl/rv_exec_pkg.sv
rtl/forward_detect.sv
rtl/operand_select.sv
rtl/alu_decoder.sv
rtl/alu.sv
rtl/execute_stage.sv
rtl/exec_top.sv
verification/tb_exec_top.sv

//--- Makefile
TOP := tb_exec_top

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f rv_exec.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f rv_exec.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir
